// File: source/hscale_pkg.sv
// horizontal scaler shared definitions
`default_nettype none

package hscale_pkg;

  ////////////////////
  // widths
  ////////////////////

  // one color channel of a pixel
  localparam int color_w = 8;

  // blend weight, 0 to 255
  localparam int weight_w = 8;

  // ctrl output register to channel result, in cycles
  // (mac input stage, products, sum)
  localparam int blend_latency = 3;

  typedef logic [color_w-1:0] color_t;
  typedef logic [weight_w-1:0] weight_t;

  // phase and step in 1/256 of an input pixel
  typedef logic [7:0] phase_t;

  ////////////////////
  // opcodes
  ////////////////////

  // how the mac input stage loads its a operands
  typedef enum logic [1:0] {
    inop_nop      = 2'b00,
    inop_normal   = 2'b01,
    inop_fir_mode = 2'b10,
    inop_reserved = 2'b11
  } inop_t;

  // sum of products or one operand passed through
  typedef enum logic [1:0] {
    calcop_normal    = 2'b00,
    calcop_bypass_a0 = 2'b01,
    calcop_bypass_a1 = 2'b10,
    calcop_reserved  = 2'b11
  } calcop_t;

  // per line scaling mode
  typedef enum logic {
    mode_linear  = 1'b0,
    mode_nearest = 1'b1
  } scale_mode_t;

endpackage

`default_nettype wire

// File: source/mult_add_2.sv
// dual multiply-add channel
`default_nettype none

module mult_add_2
  import hscale_pkg::*;
#(
  parameter int INPUT_DATA_A_W = 8,
  parameter int INPUT_DATA_B_W = 8,
  parameter int OUTPUT_DATA_W = 8,
  parameter int POST_REGS = 0
) (
  input  logic                      CLK_i,
  input  logic                      nRST_i,

  input  inop_t                     inopcode_i,
  input  calcop_t                   calcopcode_i,

  input  logic [INPUT_DATA_A_W-1:0] data_a0_i,
  input  logic [INPUT_DATA_B_W-1:0] data_b0_i,
  input  logic [INPUT_DATA_A_W-1:0] data_a1_i,
  input  logic [INPUT_DATA_B_W-1:0] data_b1_i,

  output logic [OUTPUT_DATA_W-1:0]  result_data_o
);

  // latched operands
  logic [INPUT_DATA_A_W-1:0] a0_q, a1_q;
  logic [INPUT_DATA_B_W-1:0] b0_q, b1_q;

  // calcop follows its item through the two stages after the input stage
  calcop_t calcop_q1, calcop_q2;

  // middle stage
  logic [INPUT_DATA_A_W-1:0] pick_q;
  logic [INPUT_DATA_A_W+INPUT_DATA_B_W-1:0] prod0_q, prod1_q;

  // output stage
  // weights sum to at most full scale so the sum stays in a+b bits
  logic [INPUT_DATA_A_W+INPUT_DATA_B_W-1:0] sum_q;

  ////////////////////
  // input stage
  ////////////////////

  always_ff @(posedge CLK_i or negedge nRST_i) begin
    if (!nRST_i) begin
      a0_q <= '0;
      a1_q <= '0;
      b0_q <= '0;
      b1_q <= '0;
      calcop_q1 <= calcop_normal;
      calcop_q2 <= calcop_normal;
    end else begin
      case (inopcode_i)
        inop_normal: begin
          a0_q <= data_a0_i;
          a1_q <= data_a1_i;
        end
        // new sample in, old current becomes previous
        inop_fir_mode: begin
          a0_q <= data_a0_i;
          a1_q <= a0_q;
        end
        // nop and reserved keep both
        default: begin
          a0_q <= a0_q;
          a1_q <= a1_q;
        end
      endcase
      b0_q <= data_b0_i;
      b1_q <= data_b1_i;
      calcop_q1 <= calcopcode_i;
      calcop_q2 <= calcop_q1;
    end
  end

  ////////////////////
  // products and sum
  ////////////////////

  always_ff @(posedge CLK_i or negedge nRST_i) begin
    if (!nRST_i) begin
      pick_q <= '0;
      prod0_q <= '0;
      prod1_q <= '0;
      sum_q <= '0;
    end else begin
      pick_q <= (calcop_q1 == calcop_bypass_a1) ? a1_q : a0_q;
      prod0_q <= a0_q * b0_q;
      prod1_q <= a1_q * b1_q;
      // bypass puts the pick in the top bits so the slice below returns it exactly
      if (calcop_q2 == calcop_bypass_a0 || calcop_q2 == calcop_bypass_a1) begin
        sum_q <= {pick_q, {INPUT_DATA_B_W{1'b0}}};
      end else begin
        sum_q <= prod0_q + prod1_q;
      end
    end
  end

  ////////////////////
  // optional post registers
  ////////////////////

  generate
    if (POST_REGS > 0) begin : g_post
      logic [OUTPUT_DATA_W-1:0] post_q [POST_REGS];

      always_ff @(posedge CLK_i or negedge nRST_i) begin
        if (!nRST_i) begin
          for (int i = 0; i < POST_REGS; i++) begin
            post_q[i] <= '0;
          end
        end else begin
          post_q[0] <= sum_q[INPUT_DATA_A_W+INPUT_DATA_B_W-1 -: OUTPUT_DATA_W];
          for (int i = 1; i < POST_REGS; i++) begin
            post_q[i] <= post_q[i-1];
          end
        end
      end

      assign result_data_o = post_q[POST_REGS-1];
    end else begin : g_direct
      // top bits, truncating division by the weight scale
      assign result_data_o = sum_q[INPUT_DATA_A_W+INPUT_DATA_B_W-1 -: OUTPUT_DATA_W];
    end
  endgenerate

endmodule

`default_nettype wire

// File: source/hscale_ctrl.sv
// horizontal scaler phase controller
`default_nettype none

module hscale_ctrl
  import hscale_pkg::*;
(
  input  logic        CLK_i,
  input  logic        nRST_i,

  input  logic        sol_i,
  input  logic        active_i,
  input  scale_mode_t mode_i,
  input  phase_t      step_i,

  output logic        pix_req_o,
  output inop_t       inop_o,
  output calcop_t     calcop_o,
  output weight_t     weight_a0_o,
  output weight_t     weight_a1_o,
  output logic        valid_o
);

  // accumulator state
  phase_t phase_q;
  logic   first_q;

  // next step, carry out of the sum marks a crossed input pixel
  logic [8:0] phase_sum;
  logic       first_now;
  logic       fetch;
  phase_t     frac;

  // registered active plus the delay to the channel results
  logic                     act_q;
  logic [blend_latency-1:0] valid_sr;

  ////////////////////
  // phase step
  ////////////////////

  // sol in the same cycle as an active one counts as the first fetch already
  assign first_now = sol_i | first_q;
  assign phase_sum = {1'b0, phase_q} + {1'b0, step_i};

  // first cycle of a line sits on phase 0 and always pulls a pixel
  assign frac  = first_now ? '0 : phase_sum[7:0];
  assign fetch = first_now | phase_sum[8];

  always_ff @(posedge CLK_i or negedge nRST_i) begin
    if (!nRST_i) begin
      phase_q <= '0;
      // fresh line after reset
      first_q <= 1'b1;
    end else if (active_i) begin
      phase_q <= frac;
      first_q <= 1'b0;
    end else if (sol_i) begin
      phase_q <= '0;
      first_q <= 1'b1;
    end
  end

  ////////////////////
  // registered outputs
  ////////////////////

  always_ff @(posedge CLK_i or negedge nRST_i) begin
    if (!nRST_i) begin
      pix_req_o <= 1'b0;
      inop_o <= inop_nop;
      calcop_o <= calcop_normal;
      weight_a0_o <= '0;
      weight_a1_o <= '0;
      act_q <= 1'b0;
    end else begin
      act_q <= active_i;
      if (active_i) begin
        pix_req_o <= fetch;
        // shift the fetched pixel in, previous one moves to a1
        inop_o <= fetch ? inop_fir_mode : inop_nop;
        weight_a0_o <= weight_t'(frac);
        weight_a1_o <= weight_t'(8'd255 - frac);
        if (mode_i == mode_nearest) begin
          // closer pixel wins, frac at half or above favors the current one
          calcop_o <= frac[7] ? calcop_bypass_a0 : calcop_bypass_a1;
        end else begin
          calcop_o <= calcop_normal;
        end
      end else begin
        // idle cycle, channels keep their pixels
        pix_req_o <= 1'b0;
        inop_o <= inop_nop;
        calcop_o <= calcop_normal;
      end
    end
  end

  ////////////////////
  // valid delay line
  ////////////////////

  // act_q lines up with the opcodes, the shift covers the channel pipeline
  always_ff @(posedge CLK_i or negedge nRST_i) begin
    if (!nRST_i) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[blend_latency-2:0], act_q};
    end
  end

  assign valid_o = valid_sr[blend_latency-1];

endmodule

`default_nettype wire

// File: source/hscale_top.sv
// horizontal scaler top level
`default_nettype none

module hscale_top
  import hscale_pkg::*;
(
  input  logic        CLK_i,
  input  logic        nRST_i,

  input  logic        sol_i,
  input  logic        active_i,
  input  scale_mode_t mode_i,
  input  phase_t      step_i,

  input  color_t      pix_r_i,
  input  color_t      pix_g_i,
  input  color_t      pix_b_i,

  output logic        pix_req_o,
  output color_t      out_r_o,
  output color_t      out_g_o,
  output color_t      out_b_o,
  output logic        valid_o
);

  // controller to channels, shared by all three
  inop_t   inop;
  calcop_t calcop;
  weight_t weight_a0;
  weight_t weight_a1;

  ////////////////////
  // controller
  ////////////////////

  hscale_ctrl i_ctrl (
    .CLK_i       (CLK_i),
    .nRST_i      (nRST_i),
    .sol_i       (sol_i),
    .active_i    (active_i),
    .mode_i      (mode_i),
    .step_i      (step_i),
    .pix_req_o   (pix_req_o),
    .inop_o      (inop),
    .calcop_o    (calcop),
    .weight_a0_o (weight_a0),
    .weight_a1_o (weight_a1),
    .valid_o     (valid_o)
  );

  ////////////////////
  // color channels
  ////////////////////

  // a1 input only matters for inop normal, never issued here
  mult_add_2 #(
    .INPUT_DATA_A_W (color_w),
    .INPUT_DATA_B_W (weight_w),
    .OUTPUT_DATA_W  (color_w),
    .POST_REGS      (0)
  ) i_mac_r (
    .CLK_i         (CLK_i),
    .nRST_i        (nRST_i),
    .inopcode_i    (inop),
    .calcopcode_i  (calcop),
    .data_a0_i     (pix_r_i),
    .data_b0_i     (weight_a0),
    .data_a1_i     (pix_r_i),
    .data_b1_i     (weight_a1),
    .result_data_o (out_r_o)
  );

  mult_add_2 #(
    .INPUT_DATA_A_W (color_w),
    .INPUT_DATA_B_W (weight_w),
    .OUTPUT_DATA_W  (color_w),
    .POST_REGS      (0)
  ) i_mac_g (
    .CLK_i         (CLK_i),
    .nRST_i        (nRST_i),
    .inopcode_i    (inop),
    .calcopcode_i  (calcop),
    .data_a0_i     (pix_g_i),
    .data_b0_i     (weight_a0),
    .data_a1_i     (pix_g_i),
    .data_b1_i     (weight_a1),
    .result_data_o (out_g_o)
  );

  mult_add_2 #(
    .INPUT_DATA_A_W (color_w),
    .INPUT_DATA_B_W (weight_w),
    .OUTPUT_DATA_W  (color_w),
    .POST_REGS      (0)
  ) i_mac_b (
    .CLK_i         (CLK_i),
    .nRST_i        (nRST_i),
    .inopcode_i    (inop),
    .calcopcode_i  (calcop),
    .data_a0_i     (pix_b_i),
    .data_b0_i     (weight_a0),
    .data_a1_i     (pix_b_i),
    .data_b1_i     (weight_a1),
    .result_data_o (out_b_o)
  );

endmodule

`default_nettype wire

// File: tb/hscale_sva.sv
// horizontal scaler assertions
`default_nettype none

module hscale_sva
  import hscale_pkg::*;
(
  input logic CLK_i,
  input logic nRST_i,
  input logic sol_i,
  input logic active_i,
  input logic pix_req_o,
  input logic valid_o
);

  // set by sol, cleared by the first active cycle of the line
  logic first_pending;

  always_ff @(posedge CLK_i or negedge nRST_i) begin
    if (!nRST_i) begin
      first_pending <= 1'b1;
    end else if (active_i) begin
      first_pending <= 1'b0;
    end else if (sol_i) begin
      first_pending <= 1'b1;
    end
  end

  ////////////////////
  // properties
  ////////////////////

  a_no_valid_in_reset: assert property (@(posedge CLK_i) !nRST_i |-> !valid_o)
    else $error("valid_o high during reset");

  // sampled one edge later, so the 3 cycle latency reads as 4 in $past
  a_valid_follows_active: assert property (@(posedge CLK_i) disable iff (!nRST_i)
    valid_o == $past(active_i, blend_latency + 1))
    else $error("valid_o not 3 cycles behind active_i");

  a_first_fetch: assert property (@(posedge CLK_i) disable iff (!nRST_i)
    (active_i && (sol_i || first_pending)) |=> pix_req_o)
    else $error("no pixel request on first active cycle of the line");

  // idle cycles never pull a pixel
  a_no_idle_req: assert property (@(posedge CLK_i) disable iff (!nRST_i)
    !active_i |=> !pix_req_o)
    else $error("pixel request after an idle cycle");

endmodule

bind hscale_top hscale_sva i_sva (.*);

`default_nettype wire

// File: tb/tb_hscale.sv
// horizontal scaler testbench
`default_nettype none

module tb_hscale
  import hscale_pkg::*;
();

  localparam int n_rows = 8;
  localparam int pix_depth = 256;
  localparam int clk_period = 20;
  localparam int reset_cycles = 16;
  localparam int settle_cycles = 4;

  logic        CLK_i;
  logic        nRST_i;
  logic        sol_i;
  logic        active_i;
  scale_mode_t mode_i;
  phase_t      step_i;
  color_t      pix_r_i;
  color_t      pix_g_i;
  color_t      pix_b_i;
  logic        pix_req_o;
  color_t      out_r_o;
  color_t      out_g_o;
  color_t      out_b_o;
  logic        valid_o;

  ////////////////////
  // stimulus table
  ////////////////////

  typedef struct packed {
    scale_mode_t mode;
    phase_t      step;
    int          len;
    int          gap;
  } row_t;

  // one line per row, gap is inserted halfway through the active cycles
  row_t rows [n_rows] = '{
    '{mode_linear,  8'd128, 16, 0},
    '{mode_linear,  8'd255, 20, 0},
    '{mode_nearest, 8'd64,  20, 0},
    '{mode_linear,  8'd96,  24, 5},
    '{mode_nearest, 8'd200, 18, 3},
    '{mode_linear,  8'd1,   10, 0},
    '{mode_linear,  8'd85,  30, 7},
    '{mode_nearest, 8'd128, 12, 2}
  };

  // upstream pixel source, {r, g, b}
  logic [23:0] pix_mem [pix_depth];
  logic [31:0] lfsr;
  int          drv_idx;
  logic        req_last;

  // reference model state
  scale_mode_t cur_mode;
  phase_t      cur_step;
  logic [7:0]  m_phase;
  logic        m_first;
  logic [23:0] m_cur;
  logic [23:0] m_prev;
  int          model_idx;
  logic        req_exp;
  // bit 3 is the active level now due on valid_o
  logic [3:0]  act_hist;
  logic [23:0] exp_q [$];

  hscale_top i_dut (
    .CLK_i     (CLK_i),
    .nRST_i    (nRST_i),
    .sol_i     (sol_i),
    .active_i  (active_i),
    .mode_i    (mode_i),
    .step_i    (step_i),
    .pix_r_i   (pix_r_i),
    .pix_g_i   (pix_g_i),
    .pix_b_i   (pix_b_i),
    .pix_req_o (pix_req_o),
    .out_r_o   (out_r_o),
    .out_g_o   (out_g_o),
    .out_b_o   (out_b_o),
    .valid_o   (valid_o)
  );

  always #(clk_period / 2) CLK_i = ~CLK_i;

  ////////////////////
  // helpers
  ////////////////////

  // galois lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // weighted sum over 256, truncated
  function automatic logic [7:0] blend_channel(input logic [7:0] cur, input logic [7:0] prev,
                                               input logic [7:0] frac);
    int sum;
    sum = int'(cur) * int'(frac) + int'(prev) * (255 - int'(frac));
    return sum[15:8];
  endfunction

  function automatic int run_length();
    int n;
    n = reset_cycles + settle_cycles + blend_latency + 3;
    foreach (rows[r]) begin
      n += 2 + rows[r].len + rows[r].gap;
    end
    return n;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [23:0] want, input logic [23:0] got);
    fail_run($sformatf("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, want, got));
  endtask

  // one active cycle of the phase rule, queues its expected pixel
  task automatic predict_active();
    int         sum;
    logic [7:0] frac;
    logic       fetch;
    if (m_first) begin
      frac = 8'd0;
      fetch = 1'b1;
    end else begin
      sum = int'(m_phase) + int'(cur_step);
      fetch = (sum >= 256);
      frac = sum[7:0];
    end
    m_first = 1'b0;
    m_phase = frac;
    if (fetch) begin
      assert (model_idx < pix_depth) else fail_run("pixel source ran out of pixels");
      m_prev = m_cur;
      m_cur = pix_mem[model_idx];
      model_idx++;
    end
    req_exp = fetch;
    if (cur_mode == mode_nearest) begin
      exp_q.push_back((frac >= 8'd128) ? m_cur : m_prev);
    end else begin
      exp_q.push_back({blend_channel(m_cur[23:16], m_prev[23:16], frac),
                       blend_channel(m_cur[15:8], m_prev[15:8], frac),
                       blend_channel(m_cur[7:0], m_prev[7:0], frac)});
    end
  endtask

  // check what the last edges produced, then drive the next cycle
  task automatic drive_cycle(input logic sol, input logic act);
    logic [23:0] want;
    @(negedge CLK_i);
    assert (valid_o === act_hist[3]) else value_error("valid_o", act_hist[3], valid_o);
    assert (pix_req_o === req_exp) else value_error("pix_req_o", req_exp, pix_req_o);
    if (valid_o) begin
      assert (exp_q.size() > 0) else fail_run("valid_o went high with no output expected");
      want = exp_q.pop_front();
      assert (out_r_o === want[23:16]) else value_error("out_r_o", want[23:16], out_r_o);
      assert (out_g_o === want[15:8]) else value_error("out_g_o", want[15:8], out_g_o);
      assert (out_b_o === want[7:0]) else value_error("out_b_o", want[7:0], out_b_o);
    end
    // pixel taken at the edge just passed, source moves on
    if (req_last) begin
      drv_idx++;
    end
    req_last = pix_req_o;
    {pix_r_i, pix_g_i, pix_b_i} = pix_mem[drv_idx];
    sol_i = sol;
    active_i = act;
    mode_i = cur_mode;
    step_i = cur_step;
    req_exp = 1'b0;
    if (sol) begin
      m_first = 1'b1;
      m_phase = 8'd0;
    end
    if (act) begin
      predict_active();
    end
    act_hist = {act_hist[2:0], act};
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    CLK_i = 1'b0;
    nRST_i = 1'b0;
    sol_i = 1'b0;
    active_i = 1'b0;
    mode_i = mode_linear;
    step_i = 8'd0;
    pix_r_i = 8'd0;
    pix_g_i = 8'd0;
    pix_b_i = 8'd0;
    lfsr = 32'hdf97_ee1e;
    for (int i = 0; i < pix_depth; i++) begin
      for (int b = 0; b < 24; b++) begin
        pix_mem[i] = {pix_mem[i][22:0], lfsr[0]};
        lfsr = lfsr_next(lfsr);
      end
    end
    drv_idx = 0;
    req_last = 1'b0;
    cur_mode = mode_linear;
    cur_step = 8'd128;
    m_phase = 8'd0;
    m_first = 1'b1;
    m_cur = 24'd0;
    m_prev = 24'd0;
    model_idx = 0;
    req_exp = 1'b0;
    act_hist = 4'b0000;

    repeat (reset_cycles) drive_cycle(1'b0, 1'b0);
    nRST_i = 1'b1;
    // quiet outputs until the first active cycle
    repeat (settle_cycles) drive_cycle(1'b0, 1'b0);

    foreach (rows[r]) begin
      cur_mode = rows[r].mode;
      cur_step = rows[r].step;
      drive_cycle(1'b1, 1'b0);
      for (int c = 0; c < rows[r].len; c++) begin
        if (c == rows[r].len / 2) begin
          repeat (rows[r].gap) drive_cycle(1'b0, 1'b0);
        end
        drive_cycle(1'b0, 1'b1);
      end
      drive_cycle(1'b0, 1'b0);
    end

    // let the last items leave the pipeline
    repeat (blend_latency + 3) drive_cycle(1'b0, 1'b0);
    assert (exp_q.size() == 0) else fail_run("expected outputs never appeared on valid_o");
    assert (drv_idx == model_idx) else value_error("pixel count", model_idx, drv_idx);
    $display("PASS: all tests");
    $finish;
  end

  // hang guard, twice the scheduled run plus slack
  initial begin
    #(2 * run_length() * clk_period + 1000);
    fail_run("watchdog expired, the run did not finish in time");
  end

endmodule

`default_nettype wire

// File: vlog.f
source/hscale_pkg.sv
source/mult_add_2.sv
source/hscale_ctrl.sv
source/hscale_top.sv
tb/hscale_sva.sv
tb/tb_hscale.sv

// File: Bender.yml
package:
  name: hscale

sources:
  - source/hscale_pkg.sv
  - source/mult_add_2.sv
  - source/hscale_ctrl.sv
  - source/hscale_top.sv
  - target: test
    files:
      - tb/hscale_sva.sv
      - tb/tb_hscale.sv
